//--- source/ControlPkg.sv
package ControlPkg;

  typedef logic [5:0] opcode_t;
  typedef logic [5:0] funct_t;

  localparam opcode_t opR = 6'h00;  // R-type, funct decides
  localparam opcode_t opJ = 6'h02;
  localparam opcode_t opJal = 6'h03;
  localparam opcode_t opBeq = 6'h04;
  localparam opcode_t opBne = 6'h05;
  localparam opcode_t opBle = 6'h06;
  localparam opcode_t opBgt = 6'h07;
  localparam opcode_t opAddi = 6'h08;
  localparam opcode_t opAddiu = 6'h09;
  localparam opcode_t opSlti = 6'h0A;
  localparam opcode_t opLui = 6'h0F;
  localparam opcode_t opLb = 6'h20;
  localparam opcode_t opLh = 6'h21;
  localparam opcode_t opLw = 6'h23;
  localparam opcode_t opSb = 6'h28;
  localparam opcode_t opSh = 6'h29;
  localparam opcode_t opSw = 6'h2B;

  localparam funct_t fnSll = 6'h00;
  localparam funct_t fnSrl = 6'h02;
  localparam funct_t fnSra = 6'h03;
  localparam funct_t fnSllv = 6'h04;
  localparam funct_t fnSrav = 6'h07;
  localparam funct_t fnJr = 6'h08;
  localparam funct_t fnMfhi = 6'h10;
  localparam funct_t fnMflo = 6'h12;
  localparam funct_t fnMult = 6'h18;
  localparam funct_t fnDiv = 6'h1A;
  localparam funct_t fnAdd = 6'h20;
  localparam funct_t fnSub = 6'h22;
  localparam funct_t fnAnd = 6'h24;
  localparam funct_t fnSlt = 6'h2A;

  // Codes understood by the datapath ALU control
  typedef enum logic [3:0] {
    aluPassA = 4'd0, aluAdd = 4'd1, aluSub = 4'd2, aluAnd = 4'd3,
    aluPassB = 4'd4, aluShiftL1 = 4'd5, aluShiftL2 = 4'd6, aluShiftR = 4'd7,
    aluShiftRa1 = 4'd8, aluShiftRa2 = 4'd9, aluSlt = 4'd10, aluBeq = 4'd11,
    aluBne = 4'd12, aluBle = 4'd13, aluBgt = 4'd14, aluLui = 4'd15
  } aluOp_t;

  typedef enum logic [3:0] {
    clsAluRR, clsShiftVar, clsShiftImm, clsAluImm, clsLui,
    clsMoveHiLo, clsJump, clsJumpLink, clsJumpReg, clsBranch,
    clsLoad, clsStore, clsMult, clsDiv, clsUndefined
  } insnClass_t;

  typedef enum logic [1:0] {
    sizeNone = 2'd0, sizeByte = 2'd1, sizeHalf = 2'd2, sizeWord = 2'd3
  } memSize_t;

  // Also the handler table select
  typedef enum logic [1:0] {
    causeUndefined = 2'd0, causeOverflow = 2'd1, causeDivZero = 2'd2
  } excCause_t;

  typedef enum logic [2:0] {
    pcFromAlu = 3'd0, pcFromAluOut = 3'd1, pcFromJump = 3'd2, pcFromHandler = 3'd4
  } pcSrc_t;

  typedef enum logic [2:0] {
    dataAluOut = 3'd0, dataHi = 3'd3, dataLo = 3'd4, dataPc = 3'd6
  } regDataSel_t;

  localparam logic [1:0] regDstRt = 2'd0;
  localparam logic [1:0] regDstRd = 2'd1;
  localparam logic [1:0] regDstRa = 2'd3;  // Link register

  localparam logic [1:0] memAddrPc = 2'd0;
  localparam logic [1:0] memAddrAluOut = 2'd1;
  localparam logic [1:0] memAddrHandler = 2'd3;

  localparam logic [1:0] srcAPc = 2'd0;
  localparam logic [1:0] srcAReg = 2'd1;

  localparam logic [1:0] srcBReg = 2'd0;
  localparam logic [1:0] srcBFour = 2'd1;
  localparam logic [1:0] srcBImm = 2'd2;
  localparam logic [1:0] srcBBranch = 2'd3;  // Shifted offset

  localparam int StepWidth = 4;

endpackage

//--- source/InstrDecoder.sv
`timescale 1ns/1ns

module InstrDecoder (
  input  logic clk,
  input  logic reset_in,
  input  logic decodeStrobe,
  input  ControlPkg::opcode_t opcode,
  input  ControlPkg::funct_t funct,
  output ControlPkg::insnClass_t insnClass,
  output ControlPkg::aluOp_t aluOp,
  output ControlPkg::memSize_t memSize,
  output logic ignoreOverflow
);

  ControlPkg::opcode_t opcodeQ;
  ControlPkg::funct_t functQ;

  always_ff @(posedge clk) begin
    if (reset_in) begin
      opcodeQ <= ControlPkg::opR;
      functQ <= ControlPkg::fnSll;
    end else if (decodeStrobe) begin  // Held until the next decode
      opcodeQ <= opcode;
      functQ <= funct;
    end
  end

  always_comb begin
    case (opcodeQ)
      ControlPkg::opR: begin
        case (functQ)
          ControlPkg::fnAdd, ControlPkg::fnAnd,
          ControlPkg::fnSub, ControlPkg::fnSlt: insnClass = ControlPkg::clsAluRR;
          ControlPkg::fnSllv, ControlPkg::fnSrav: insnClass = ControlPkg::clsShiftVar;
          ControlPkg::fnSll, ControlPkg::fnSra,
          ControlPkg::fnSrl: insnClass = ControlPkg::clsShiftImm;
          ControlPkg::fnMfhi, ControlPkg::fnMflo: insnClass = ControlPkg::clsMoveHiLo;
          ControlPkg::fnJr: insnClass = ControlPkg::clsJumpReg;
          ControlPkg::fnMult: insnClass = ControlPkg::clsMult;
          ControlPkg::fnDiv: insnClass = ControlPkg::clsDiv;
          default: insnClass = ControlPkg::clsUndefined;
        endcase
      end
      ControlPkg::opAddi, ControlPkg::opAddiu,
      ControlPkg::opSlti: insnClass = ControlPkg::clsAluImm;
      ControlPkg::opLui: insnClass = ControlPkg::clsLui;
      ControlPkg::opJ: insnClass = ControlPkg::clsJump;
      ControlPkg::opJal: insnClass = ControlPkg::clsJumpLink;
      ControlPkg::opBeq, ControlPkg::opBne,
      ControlPkg::opBle, ControlPkg::opBgt: insnClass = ControlPkg::clsBranch;
      ControlPkg::opLb, ControlPkg::opLh, ControlPkg::opLw: insnClass = ControlPkg::clsLoad;
      ControlPkg::opSb, ControlPkg::opSh, ControlPkg::opSw: insnClass = ControlPkg::clsStore;
      default: insnClass = ControlPkg::clsUndefined;
    endcase
  end

  // mfhi and mflo tell apart by passA and passB, the ALU is idle for them
  always_comb begin
    case (opcodeQ)
      ControlPkg::opR: begin
        case (functQ)
          ControlPkg::fnAdd: aluOp = ControlPkg::aluAdd;
          ControlPkg::fnAnd: aluOp = ControlPkg::aluAnd;
          ControlPkg::fnSub: aluOp = ControlPkg::aluSub;
          ControlPkg::fnSlt: aluOp = ControlPkg::aluSlt;
          ControlPkg::fnSllv: aluOp = ControlPkg::aluShiftL2;
          ControlPkg::fnSrav: aluOp = ControlPkg::aluShiftRa2;
          ControlPkg::fnSll: aluOp = ControlPkg::aluShiftL1;
          ControlPkg::fnSra: aluOp = ControlPkg::aluShiftRa1;
          ControlPkg::fnSrl: aluOp = ControlPkg::aluShiftR;
          ControlPkg::fnMflo: aluOp = ControlPkg::aluPassB;
          default: aluOp = ControlPkg::aluPassA;
        endcase
      end
      ControlPkg::opSlti: aluOp = ControlPkg::aluSlt;
      ControlPkg::opLui: aluOp = ControlPkg::aluLui;
      ControlPkg::opBeq: aluOp = ControlPkg::aluBeq;
      ControlPkg::opBne: aluOp = ControlPkg::aluBne;
      ControlPkg::opBle: aluOp = ControlPkg::aluBle;
      ControlPkg::opBgt: aluOp = ControlPkg::aluBgt;
      default: aluOp = ControlPkg::aluAdd;  // Immediates and address calc
    endcase
  end

  always_comb begin
    case (opcodeQ)
      ControlPkg::opLb, ControlPkg::opSb: memSize = ControlPkg::sizeByte;
      ControlPkg::opLh, ControlPkg::opSh: memSize = ControlPkg::sizeHalf;
      ControlPkg::opLw, ControlPkg::opSw: memSize = ControlPkg::sizeWord;
      default: memSize = ControlPkg::sizeNone;
    endcase
  end

  assign ignoreOverflow = (opcodeQ == ControlPkg::opAddiu);

endmodule

//--- source/ExceptionTracker.sv
`timescale 1ns/1ns

module ExceptionTracker (
  input  logic clk,
  input  logic reset_in,
  input  logic [1:0] excFlags,  // Overflow, divide by zero
  input  logic ignoreOverflow,
  input  logic excServiced,
  output logic excPending,
  output ControlPkg::excCause_t excCause
);

  logic overflowQ;
  logic divZeroQ;

  // Sticky until serviced, a new flag in the same cycle survives the clear
  always_ff @(posedge clk) begin
    if (reset_in) begin
      overflowQ <= 1'b0;
      divZeroQ <= 1'b0;
    end else begin
      overflowQ <= (overflowQ & ~excServiced) | (excFlags[1] & ~ignoreOverflow);
      divZeroQ <= (divZeroQ & ~excServiced) | excFlags[0];
    end
  end

  assign excPending = overflowQ | divZeroQ;
  assign excCause = overflowQ ? ControlPkg::causeOverflow : ControlPkg::causeDivZero;

  // Service only ever follows a real pending cause
  serviceNeedsCause: assert property (@(posedge clk) disable iff (reset_in)
    excServiced |-> excPending);

endmodule

//--- source/StepSequencer.sv
`timescale 1ns/1ns

module StepSequencer #(
  parameter int MaxStep = 8
) (
  input  logic clk,
  input  logic reset_in,
  input  logic branchTaken,
  input  logic multDone,
  input  logic divDone,
  input  ControlPkg::insnClass_t insnClass,
  input  ControlPkg::aluOp_t insnAluOp,
  input  ControlPkg::memSize_t memSize,
  input  logic excPending,
  input  ControlPkg::excCause_t excCause,
  output logic decodeStrobe,
  output logic excServiced,
  output logic resetOut,
  output logic pcWrite,
  output logic epcWrite,
  output logic memWrite,
  output logic irWrite,
  output logic [1:0] regDstSel,
  output ControlPkg::regDataSel_t regDataSel,
  output logic [1:0] memAddrSel,
  output ControlPkg::pcSrc_t pcSrcSel,
  output logic [1:0] aluSrcASel,
  output logic [1:0] aluSrcBSel,
  output ControlPkg::excCause_t excCauseSel,
  output logic aluOutWrite,
  output logic regFileWrite,
  output logic aRegWrite,
  output logic bRegWrite,
  output logic hiWrite,
  output logic loWrite,
  output logic memDataWrite,
  output logic multStart,
  output logic multReset,
  output ControlPkg::memSize_t loadSize,
  output ControlPkg::memSize_t storeSize,
  output logic divStart,
  output logic divReset,
  output ControlPkg::aluOp_t aluOp
);

  localparam logic [2:0] phReset = 3'd0;
  localparam logic [2:0] phFetch = 3'd1;
  localparam logic [2:0] phExecute = 3'd2;
  localparam logic [2:0] phException = 3'd3;
  localparam logic [2:0] phMemWait = 3'd4;

  logic [2:0] phase;
  logic [ControlPkg::StepWidth-1:0] step;
  logic [ControlPkg::StepWidth-1:0] lastStep;
  logic undefEntry;  // Exception came from decode, not the tracker
  logic unitWait;
  logic execDone;

  always_comb begin
    case (insnClass)
      ControlPkg::clsMoveHiLo, ControlPkg::clsJump, ControlPkg::clsJumpLink: lastStep = 4'd1;
      ControlPkg::clsLui: lastStep = 4'd3;
      ControlPkg::clsShiftVar, ControlPkg::clsMult: lastStep = 4'd5;
      ControlPkg::clsLoad, ControlPkg::clsStore: lastStep = 4'd8;
      ControlPkg::clsUndefined: lastStep = 4'd0;
      default: lastStep = 4'd4;
    endcase
  end

  assign unitWait = (phase == phExecute) &&
    ((insnClass == ControlPkg::clsMult && step == 4'd3 && multDone) ||
     (insnClass == ControlPkg::clsDiv && step == 4'd2 && !divDone));
  assign execDone = (step == lastStep) ||
    (insnClass == ControlPkg::clsBranch && step == 4'd2 && !branchTaken);

  always_ff @(posedge clk) begin
    if (reset_in) begin
      phase <= phReset;
      step <= '0;
      undefEntry <= 1'b0;
    end else begin
      case (phase)
        phFetch: begin
          if (step == 4'd0 && excPending) begin
            phase <= phException;
            undefEntry <= 1'b0;
          end else if (step == 4'd2) begin
            phase <= phExecute;
            step <= '0;
          end else begin
            step <= step + 1'b1;
          end
        end
        phExecute: begin
          if (insnClass == ControlPkg::clsUndefined) begin
            phase <= phException;
            step <= '0;
            undefEntry <= 1'b1;
          end else if (execDone) begin
            phase <= phFetch;
            step <= '0;
          end else if (!unitWait) begin
            step <= step + 1'b1;
          end
        end
        phException: begin
          step <= (step == 4'd4) ? '0 : step + 1'b1;
          if (step == 4'd4) phase <= phMemWait;
        end
        phMemWait: begin
          step <= (step == 4'd1) ? '0 : step + 1'b1;
          if (step == 4'd1) phase <= phFetch;
        end
        default: begin  // Reset phase lasts one cycle past release
          phase <= phFetch;
          step <= '0;
        end
      endcase
    end
  end

  always_comb begin
    decodeStrobe = 1'b0;
    excServiced = 1'b0;
    resetOut = 1'b0;
    pcWrite = 1'b0;
    epcWrite = 1'b0;
    memWrite = 1'b0;
    irWrite = 1'b0;
    regDstSel = ControlPkg::regDstRt;
    regDataSel = ControlPkg::dataAluOut;
    memAddrSel = ControlPkg::memAddrPc;
    pcSrcSel = ControlPkg::pcFromAlu;
    aluSrcASel = ControlPkg::srcAPc;
    aluSrcBSel = ControlPkg::srcBReg;
    excCauseSel = ControlPkg::causeUndefined;
    aluOutWrite = 1'b0;
    regFileWrite = 1'b0;
    aRegWrite = 1'b0;
    bRegWrite = 1'b0;
    hiWrite = 1'b0;
    loWrite = 1'b0;
    memDataWrite = 1'b0;
    multStart = 1'b0;
    multReset = 1'b1;  // Units held in reset when idle
    loadSize = ControlPkg::sizeNone;
    storeSize = ControlPkg::sizeNone;
    divStart = 1'b0;
    divReset = 1'b1;
    aluOp = ControlPkg::aluPassA;
    case (phase)
      phReset: resetOut = 1'b1;
      phFetch: begin  // PC + 4 into ALUOut, written back at step 2
        pcSrcSel = ControlPkg::pcFromAluOut;
        aluSrcBSel = ControlPkg::srcBFour;
        aluOp = ControlPkg::aluAdd;
        irWrite = (step == 4'd0) && !excPending;
        aluOutWrite = (step == 4'd0) && !excPending;
        pcWrite = (step == 4'd2);
        decodeStrobe = (step == 4'd2);
      end
      phException: begin  // EPC gets PC - 4, PC gets the handler
        aluSrcBSel = ControlPkg::srcBFour;
        aluOp = ControlPkg::aluSub;
        memAddrSel = ControlPkg::memAddrHandler;
        pcSrcSel = ControlPkg::pcFromHandler;
        excCauseSel = undefEntry ? ControlPkg::causeUndefined : excCause;
        aluOutWrite = (step == 4'd0);
        epcWrite = (step == 4'd2);
        pcWrite = (step == 4'd2);
        excServiced = (step == 4'd4) && !undefEntry;
      end
      phExecute: begin
        case (insnClass)
          ControlPkg::clsAluRR, ControlPkg::clsShiftVar, ControlPkg::clsShiftImm,
          ControlPkg::clsAluImm, ControlPkg::clsLui: begin
            aluOp = insnAluOp;
            aluSrcASel = ControlPkg::srcAReg;
            if (insnClass == ControlPkg::clsAluImm || insnClass == ControlPkg::clsLui) begin
              aluSrcBSel = ControlPkg::srcBImm;
            end else begin
              regDstSel = ControlPkg::regDstRd;
            end
            aRegWrite = (step == 4'd0) && insnClass != ControlPkg::clsShiftImm &&
              insnClass != ControlPkg::clsLui;
            bRegWrite = (step == 4'd0) && (insnClass == ControlPkg::clsAluRR ||
              insnClass == ControlPkg::clsShiftVar || insnClass == ControlPkg::clsShiftImm);
            // Variable shifts need an extra cycle in the shifter
            aluOutWrite = (step == ((insnClass == ControlPkg::clsShiftVar) ? 4'd2 : 4'd1));
            regFileWrite = (step == ((insnClass == ControlPkg::clsShiftVar) ? 4'd3 : 4'd2));
          end
          ControlPkg::clsMoveHiLo: begin
            regDstSel = ControlPkg::regDstRd;
            regDataSel = (insnAluOp == ControlPkg::aluPassB) ? ControlPkg::dataLo :
              ControlPkg::dataHi;
            regFileWrite = (step == 4'd0);
          end
          ControlPkg::clsJump, ControlPkg::clsJumpLink: begin
            pcSrcSel = ControlPkg::pcFromJump;
            pcWrite = (step == 4'd0);
            if (insnClass == ControlPkg::clsJumpLink) begin  // Return address into ra
              regDstSel = ControlPkg::regDstRa;
              regDataSel = ControlPkg::dataPc;
              regFileWrite = (step == 4'd0);
            end
          end
          ControlPkg::clsJumpReg: begin
            aluSrcASel = ControlPkg::srcAReg;
            aRegWrite = (step == 4'd0);
            pcWrite = (step == 4'd2);
          end
          ControlPkg::clsBranch: begin
            aRegWrite = (step == 4'd0);
            bRegWrite = (step == 4'd0);
            if (step < 4'd3) begin  // Compare until branchTaken is sampled
              aluSrcASel = ControlPkg::srcAReg;
              aluOp = insnAluOp;
            end else begin
              aluSrcBSel = ControlPkg::srcBBranch;
              aluOp = ControlPkg::aluAdd;
            end
            pcWrite = (step == 4'd3);
          end
          ControlPkg::clsLoad, ControlPkg::clsStore: begin
            aluSrcASel = ControlPkg::srcAReg;
            aluSrcBSel = ControlPkg::srcBImm;
            aluOp = ControlPkg::aluAdd;
            aRegWrite = (step == 4'd0);
            bRegWrite = (step == 4'd0) && insnClass == ControlPkg::clsStore;
            aluOutWrite = (step == 4'd1);
            if (step >= 4'd2 && step <= 4'd7) memAddrSel = ControlPkg::memAddrAluOut;
            memDataWrite = (step == 4'd4);
            if (insnClass == ControlPkg::clsLoad) begin
              if (step == 4'd5 || step == 4'd6) loadSize = memSize;
              regFileWrite = (step == 4'd6);
            end else begin
              if (step == 4'd5 || step == 4'd6) storeSize = memSize;
              memWrite = (step == 4'd6);
            end
          end
          ControlPkg::clsMult: begin
            aRegWrite = (step == 4'd0);
            bRegWrite = (step == 4'd0);
            multReset = (step == 4'd0) || (step == 4'd5);
            multStart = (step >= 4'd1) && (step <= 4'd3);  // Held until multDone drops
            hiWrite = (step == 4'd4);
            loWrite = (step == 4'd4);
          end
          ControlPkg::clsDiv: begin
            aRegWrite = (step == 4'd0);
            bRegWrite = (step == 4'd0);
            divReset = (step == 4'd0) || (step == 4'd4);
            divStart = (step == 4'd1) || (step == 4'd2);
            hiWrite = (step == 4'd3);
            loWrite = (step == 4'd3);
          end
          default: ;  // Undefined leaves for the exception sequence
        endcase
      end
      default: ;  // Memory wait after exception entry
    endcase
  end

  stepBounded: assert property (@(posedge clk) disable iff (reset_in)
    (step <= MaxStep) || unitWait);

  noIrAndRegWrite: assert property (@(posedge clk) disable iff (reset_in)
    !(irWrite && regFileWrite));

endmodule

//--- source/ControlUnit.sv
`timescale 1ns/1ns

module ControlUnit #(
  parameter int MaxStep = 8  // Longest sequence, loads and stores
) (
  input  logic clk,
  input  logic reset_in,
  input  ControlPkg::opcode_t opcode,
  input  ControlPkg::funct_t funct,
  input  logic branchTaken,
  input  logic multDone,
  input  logic divDone,
  input  logic [1:0] excFlags,
  output logic resetOut,
  output logic pcWrite,
  output logic epcWrite,
  output logic memWrite,
  output logic irWrite,
  output logic [1:0] regDstSel,
  output ControlPkg::regDataSel_t regDataSel,
  output logic [1:0] memAddrSel,
  output ControlPkg::pcSrc_t pcSrcSel,
  output logic [1:0] aluSrcASel,
  output logic [1:0] aluSrcBSel,
  output ControlPkg::excCause_t excCauseSel,
  output logic aluOutWrite,
  output logic regFileWrite,
  output logic aRegWrite,
  output logic bRegWrite,
  output logic hiWrite,
  output logic loWrite,
  output logic memDataWrite,
  output logic multStart,
  output logic multReset,
  output ControlPkg::memSize_t loadSize,
  output ControlPkg::memSize_t storeSize,
  output logic divStart,
  output logic divReset,
  output ControlPkg::aluOp_t aluOp
);

  logic decodeStrobe;
  logic excServiced;
  logic ignoreOverflow;
  logic excPending;
  ControlPkg::insnClass_t insnClass;
  ControlPkg::aluOp_t insnAluOp;  // Decoded op, the sequencer chooses when to use it
  ControlPkg::memSize_t memSize;
  ControlPkg::excCause_t excCause;

  InstrDecoder decoder (
    .aluOp(insnAluOp),
    .*
  );

  ExceptionTracker tracker (.*);

  StepSequencer #(
    .MaxStep(MaxStep)
  ) sequencer (.*);

endmodule

//--- sim/ControlUnitTb.sv
`timescale 1ns/1ns

module ControlUnitTb;

  localparam int TimeoutCycles = 600;  // About twice the full sequence of tests

  logic clk = 1'b0;
  logic reset_in;
  ControlPkg::opcode_t opcode;
  ControlPkg::funct_t funct;
  logic branchTaken, multDone, divDone;
  logic [1:0] excFlags;
  logic resetOut, pcWrite, epcWrite, memWrite, irWrite;
  logic [1:0] regDstSel, memAddrSel, aluSrcASel, aluSrcBSel;
  ControlPkg::regDataSel_t regDataSel;
  ControlPkg::pcSrc_t pcSrcSel;
  ControlPkg::excCause_t excCauseSel;
  logic aluOutWrite, regFileWrite, aRegWrite, bRegWrite, hiWrite, loWrite;
  logic memDataWrite, multStart, multReset, divStart, divReset;
  ControlPkg::memSize_t loadSize, storeSize;
  ControlPkg::aluOp_t aluOp;

  // What the last instruction did between its irWrite and the next one
  int cycles, nReg, nPc, nEpc, nMem, nHi, hiCycle, doneCycle;
  ControlPkg::aluOp_t aluAtReg;
  ControlPkg::memSize_t loadAtReg, storeAtMem;
  ControlPkg::regDataSel_t dataAtReg;
  ControlPkg::pcSrc_t pcSrcLast;
  ControlPkg::excCause_t causeAtEpc;
  logic [1:0] regDstAtReg, addrAtMem;
  integer seed = 32'ha387;
  int cycleCount = 0;

  ControlUnit #(.MaxStep(8)) UUT (.*);

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= TimeoutCycles) begin
      $display("Timeout after %0d cycles, the instruction sequence did not finish", cycleCount);
      abortRun();
    end
  end

  task automatic abortRun();
    $display("Simulation failed");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic compareBit(input string name, input logic act, input logic exp);
    if (act !== exp) begin
      $display("CHECK FAILED at %0t: %s is %b, expected %b", $time, name, act, exp);
      abortRun();
    end
  endtask

  task automatic compareCount(input string name, input int act, input int exp);
    if (act != exp) begin
      $display("CHECK FAILED at %0t: %s is %0d, expected %0d", $time, name, act, exp);
      abortRun();
    end
  endtask

  task automatic compareSel(input string name, input logic [1:0] act,
                            input logic [1:0] exp);
    if (act !== exp) begin
      $display("CHECK FAILED at %0t: %s is %0d, expected %0d", $time, name, act, exp);
      abortRun();
    end
  endtask

  task automatic compareAluOp(input string name, input ControlPkg::aluOp_t act,
                              input ControlPkg::aluOp_t exp);
    if (act !== exp) begin
      $display("CHECK FAILED at %0t: %s is %0d, expected %0d", $time, name, act, exp);
      abortRun();
    end
  endtask

  task automatic compareSize(input string name, input ControlPkg::memSize_t act,
                             input ControlPkg::memSize_t exp);
    if (act !== exp) begin
      $display("CHECK FAILED at %0t: %s is %0d, expected %0d", $time, name, act, exp);
      abortRun();
    end
  endtask

  task automatic compareCause(input string name, input ControlPkg::excCause_t act,
                              input ControlPkg::excCause_t exp);
    if (act !== exp) begin
      $display("CHECK FAILED at %0t: %s is %0d, expected %0d", $time, name, act, exp);
      abortRun();
    end
  endtask

  task automatic comparePcSrc(input string name, input ControlPkg::pcSrc_t act,
                              input ControlPkg::pcSrc_t exp);
    if (act !== exp) begin
      $display("CHECK FAILED at %0t: %s is %0d, expected %0d", $time, name, act, exp);
      abortRun();
    end
  endtask

  task automatic compareDataSel(input string name, input ControlPkg::regDataSel_t act,
                                input ControlPkg::regDataSel_t exp);
    if (act !== exp) begin
      $display("CHECK FAILED at %0t: %s is %0d, expected %0d", $time, name, act, exp);
      abortRun();
    end
  endtask

  // Runs from one irWrite falling edge to the next
  task automatic runInsn(input ControlPkg::opcode_t op, input ControlPkg::funct_t fn,
                         input logic taken, input logic [1:0] flags, input int flagCycle);
    int delay;
    int remaining;
    logic armed;
    logic isMult;
    logic finished;
    delay = 2 + int'($unsigned($random(seed)) % 6);
    remaining = 0;
    armed = 1'b0;
    isMult = 1'b0;
    finished = 1'b0;
    cycles = 0;
    nReg = 0;
    nPc = 0;
    nEpc = 0;
    nMem = 0;
    nHi = 0;
    hiCycle = -1;
    doneCycle = -1;
    opcode = op;
    funct = fn;
    branchTaken = taken;
    multDone = 1'b0;
    divDone = 1'b0;
    while (!finished) begin
      @(negedge clk);
      cycles++;
      if (irWrite) begin
        finished = 1'b1;
        // Fetch step 0 puts PC + 4 into ALUOut
        compareBit("aluOutWrite", aluOutWrite, 1'b1);
        compareSel("aluSrcASel", aluSrcASel, ControlPkg::srcAPc);
        compareSel("aluSrcBSel", aluSrcBSel, ControlPkg::srcBFour);
        compareSel("memAddrSel", memAddrSel, ControlPkg::memAddrPc);
        compareAluOp("aluOp", aluOp, ControlPkg::aluAdd);
        comparePcSrc("pcSrcSel", pcSrcSel, ControlPkg::pcFromAluOut);
      end else begin
        if (regFileWrite) begin
          nReg++;
          aluAtReg = aluOp;
          loadAtReg = loadSize;
          dataAtReg = regDataSel;
          regDstAtReg = regDstSel;
        end
        if (pcWrite) begin
          nPc++;
          pcSrcLast = pcSrcSel;
        end
        if (epcWrite) begin
          nEpc++;
          causeAtEpc = excCauseSel;
        end
        if (memWrite) begin
          nMem++;
          storeAtMem = storeSize;
          addrAtMem = memAddrSel;
        end
        if (hiWrite) begin
          nHi++;
          hiCycle = cycles;
        end
        compareBit("loWrite", loWrite, hiWrite);  // Hi and lo go together
        // Multiplier done is a busy level and divider done marks the end
        if (!armed && (multStart || divStart)) begin
          armed = 1'b1;
          isMult = multStart;
          remaining = delay;
          multDone = multStart;
        end else if (armed && remaining > 0) begin
          remaining--;
          if (remaining == 0) begin
            doneCycle = cycles;
            multDone = 1'b0;
            divDone = !isMult;
          end
        end
      end
      excFlags = (cycles == flagCycle) ? flags : 2'b00;
    end
  endtask

  task automatic testReset();
    repeat (8) begin
      @(negedge clk);
      compareBit("resetOut", resetOut, 1'b1);
      compareBit("multReset", multReset, 1'b1);
      compareBit("divReset", divReset, 1'b1);
      compareCount("enables in reset", int'({pcWrite, epcWrite, memWrite, irWrite,
        regFileWrite, aluOutWrite, aRegWrite, bRegWrite, hiWrite, loWrite,
        memDataWrite, multStart, divStart}), 0);
    end
    reset_in = 1'b0;
    @(negedge clk);
    compareBit("resetOut", resetOut, 1'b0);
    compareBit("irWrite", irWrite, 1'b1);
  endtask

  task automatic checkRegOp(input ControlPkg::opcode_t op, input ControlPkg::funct_t fn,
                            input int expCycles, input ControlPkg::aluOp_t expAlu);
    runInsn(op, fn, 1'b0, 2'b00, -1);
    compareCount("cycles between irWrite", cycles, expCycles);
    compareCount("regFileWrite pulses", nReg, 1);
    compareAluOp("aluOp", aluAtReg, expAlu);
    compareSel("regDstSel", regDstAtReg,
      (op == ControlPkg::opR) ? ControlPkg::regDstRd : ControlPkg::regDstRt);
  endtask

  task automatic testAluShift();
    checkRegOp(ControlPkg::opR, ControlPkg::fnAdd, 8, ControlPkg::aluAdd);
    checkRegOp(ControlPkg::opR, ControlPkg::fnAnd, 8, ControlPkg::aluAnd);
    checkRegOp(ControlPkg::opR, ControlPkg::fnSub, 8, ControlPkg::aluSub);
    checkRegOp(ControlPkg::opR, ControlPkg::fnSlt, 8, ControlPkg::aluSlt);
    checkRegOp(ControlPkg::opR, ControlPkg::fnSllv, 9, ControlPkg::aluShiftL2);
    checkRegOp(ControlPkg::opR, ControlPkg::fnSrav, 9, ControlPkg::aluShiftRa2);
    checkRegOp(ControlPkg::opR, ControlPkg::fnSll, 8, ControlPkg::aluShiftL1);
    checkRegOp(ControlPkg::opR, ControlPkg::fnSra, 8, ControlPkg::aluShiftRa1);
    checkRegOp(ControlPkg::opR, ControlPkg::fnSrl, 8, ControlPkg::aluShiftR);
    checkRegOp(ControlPkg::opAddi, 6'h00, 8, ControlPkg::aluAdd);
    checkRegOp(ControlPkg::opSlti, 6'h00, 8, ControlPkg::aluSlt);
    checkRegOp(ControlPkg::opLui, 6'h00, 7, ControlPkg::aluLui);
    runInsn(ControlPkg::opR, ControlPkg::fnMfhi, 1'b0, 2'b00, -1);
    compareCount("cycles between irWrite", cycles, 5);
    compareDataSel("regDataSel", dataAtReg, ControlPkg::dataHi);
    runInsn(ControlPkg::opR, ControlPkg::fnMflo, 1'b0, 2'b00, -1);
    compareDataSel("regDataSel", dataAtReg, ControlPkg::dataLo);
  endtask

  task automatic testBranchJump();
    runInsn(ControlPkg::opBeq, 6'h00, 1'b0, 2'b00, -1);
    compareCount("cycles between irWrite", cycles, 6);
    compareCount("pcWrite pulses", nPc, 1);
    runInsn(ControlPkg::opBgt, 6'h00, 1'b1, 2'b00, -1);
    compareCount("cycles between irWrite", cycles, 8);
    compareCount("pcWrite pulses", nPc, 2);
    comparePcSrc("pcSrcSel", pcSrcLast, ControlPkg::pcFromAlu);
    runInsn(ControlPkg::opJ, 6'h00, 1'b0, 2'b00, -1);
    compareCount("cycles between irWrite", cycles, 5);
    comparePcSrc("pcSrcSel", pcSrcLast, ControlPkg::pcFromJump);
    runInsn(ControlPkg::opJal, 6'h00, 1'b0, 2'b00, -1);
    compareCount("regFileWrite pulses", nReg, 1);
    compareDataSel("regDataSel", dataAtReg, ControlPkg::dataPc);
    compareSel("regDstSel", regDstAtReg, ControlPkg::regDstRa);
    runInsn(ControlPkg::opR, ControlPkg::fnJr, 1'b0, 2'b00, -1);
    compareCount("cycles between irWrite", cycles, 8);
  endtask

  task automatic checkMem(input ControlPkg::opcode_t op, input logic isStore,
                          input ControlPkg::memSize_t size);
    runInsn(op, 6'h00, 1'b0, 2'b00, -1);
    compareCount("cycles between irWrite", cycles, 12);
    compareCount("memWrite pulses", nMem, isStore ? 1 : 0);
    compareCount("regFileWrite pulses", nReg, isStore ? 0 : 1);
    if (isStore) begin
      compareSize("storeSize", storeAtMem, size);
      compareSel("memAddrSel", addrAtMem, ControlPkg::memAddrAluOut);
    end else begin
      compareSize("loadSize", loadAtReg, size);
    end
  endtask

  task automatic checkUnit(input ControlPkg::funct_t fn);
    runInsn(ControlPkg::opR, fn, 1'b0, 2'b00, -1);
    compareCount("hiWrite pulses", nHi, 1);
    compareCount("hiWrite cycle", hiCycle, doneCycle + 1);  // First edge after done
    compareCount("cycles between irWrite", cycles, hiCycle + 2);
  endtask

  task automatic testExceptions();
    runInsn(6'h3F, 6'h00, 1'b0, 2'b00, -1);  // Unused opcode
    compareCount("cycles between irWrite", cycles, 11);
    compareCount("epcWrite pulses", nEpc, 1);
    compareCause("excCauseSel", causeAtEpc, ControlPkg::causeUndefined);
    runInsn(ControlPkg::opAddi, 6'h00, 1'b0, 2'b10, 4);
    compareCount("cycles between irWrite", cycles, 16);
    compareCount("epcWrite pulses", nEpc, 1);
    compareCause("excCauseSel", causeAtEpc, ControlPkg::causeOverflow);
    runInsn(ControlPkg::opAddiu, 6'h00, 1'b0, 2'b10, 4);
    compareCount("cycles between irWrite", cycles, 8);
    compareCount("epcWrite pulses", nEpc, 0);
    runInsn(ControlPkg::opR, ControlPkg::fnDiv, 1'b0, 2'b01, 4);
    compareCount("epcWrite pulses", nEpc, 1);
    compareCause("excCauseSel", causeAtEpc, ControlPkg::causeDivZero);
    compareCount("cycles between irWrite", cycles, hiCycle + 10);  // Detect, service, wait
  endtask

  initial begin
    reset_in = 1'b1;
    opcode = '0;
    funct = '0;
    branchTaken = 1'b0;
    multDone = 1'b0;
    divDone = 1'b0;
    excFlags = 2'b00;
    testReset();
    testAluShift();
    testBranchJump();
    checkMem(ControlPkg::opLb, 1'b0, ControlPkg::sizeByte);
    checkMem(ControlPkg::opLh, 1'b0, ControlPkg::sizeHalf);
    checkMem(ControlPkg::opLw, 1'b0, ControlPkg::sizeWord);
    checkMem(ControlPkg::opSb, 1'b1, ControlPkg::sizeByte);
    checkMem(ControlPkg::opSh, 1'b1, ControlPkg::sizeHalf);
    checkMem(ControlPkg::opSw, 1'b1, ControlPkg::sizeWord);
    checkUnit(ControlPkg::fnMult);
    checkUnit(ControlPkg::fnDiv);
    testExceptions();
    $display("Simulation passed");
    $finish;
  end

endmodule

//--- compile.f
source/ControlPkg.sv
source/InstrDecoder.sv
source/ExceptionTracker.sv
source/StepSequencer.sv
source/ControlUnit.sv
sim/ControlUnitTb.sv

//--- Makefile
# Verilator build and run of the control unit testbench

VERILATOR ?= verilator
TOP       ?= ControlUnitTb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build $(TOP) with Verilator, run it, look for the pass line in $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "Simulation passed" $(LOG) || { echo "test: no pass line in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
